// File: src/acc_cpu_pkg.sv
/*
  Shared types and encodings for the 16-bit accumulator processor.
  Addresses are word addresses, so the pc steps by one per instruction.
  Instruction word: [15:12] opcode, [11] memory operand select,
  [10:0] immediate, direct address, branch offset or condition in [1:0].
  A direct address reaches only the low 2K words of memory.
*/
package acc_cpu_pkg;

  localparam int WORD_W    = 16;
  localparam int OPERAND_W = 11;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [WORD_W-1:0]    addr_t;
  typedef logic [OPERAND_W-1:0] operand_t;

  localparam addr_t RESET_PC = '0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [3:0] {
    op_nop    = 4'h0,
    op_load   = 4'h1,
    op_store  = 4'h2,
    op_add    = 4'h3,
    op_sub    = 4'h4,
    op_and    = 4'h5,
    op_or     = 4'h6,
    op_xor    = 4'h7,
    op_test   = 4'h8,
    op_branch = 4'h9,
    op_if     = 4'hA,
    op_out_lo = 4'hB,
    op_out_hi = 4'hC,
    op_halt   = 4'hD,
    op_trap   = 4'hE,
    op_undef  = 4'hF   // traps.
  } op_e;

  typedef enum logic [1:0] {
    cond_zero     = 2'd0,
    cond_not_zero = 2'd1,
    cond_neg      = 2'd2,
    cond_not_neg  = 2'd3
  } cond_e;

  typedef enum logic [2:0] {
    st_idle,
    st_fetch,
    st_exec,
    st_mem,
    st_halt,
    st_trap
  } cpu_state_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bundles
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    op_e      op;
    logic     use_mem;
    operand_t operand;
    word_t    imm;       // operand, sign extended.
    cond_e    cond;
    logic     illegal;
  } inst_fields_t;

  typedef struct packed {
    addr_t addr;
    word_t wdata;
    logic  write;
  } mem_cmd_t;

endpackage

// File: src/inst_decoder.sv
/*
  Combinational instruction decoder.
  Illegal forms are opcode F and a store with an immediate operand.
  The condition field is taken from bits 1:0 for every opcode and only
  means something for an if.
*/
`timescale 1ns/1ps

module inst_decoder
  import acc_cpu_pkg::*;
(
  input  word_t        inst,
  output inst_fields_t fields
);

  op_e      op;
  logic     use_mem;
  operand_t operand;
  logic     illegal;

  assign op      = op_e'(inst[WORD_W-1 -: 4]);
  assign use_mem = inst[OPERAND_W];
  assign operand = inst[OPERAND_W-1:0];

  always_comb begin
    case (op)
      op_undef: illegal = 1'b1;
      op_store: illegal = !use_mem;  // a store needs an address.
      default:  illegal = 1'b0;
    endcase
  end

  always_comb begin
    fields.op      = op;
    fields.use_mem = use_mem;
    fields.operand = operand;
    fields.imm     = {{(WORD_W-OPERAND_W){operand[OPERAND_W-1]}}, operand};
    fields.cond    = cond_e'(inst[1:0]);
    fields.illegal = illegal;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // no clock here, so the check is deferred to the end of the time step.
  a_store_imm_illegal: assert final (
    $isunknown(inst) ||
    !(inst[WORD_W-1:WORD_W-4] == op_store && !inst[OPERAND_W]) ||
    fields.illegal
  ) else $error("store with immediate operand not flagged illegal.");

endmodule

// File: src/alu_flags.sv
/*
  Accumulator ALU for the data operations.
  Load passes the operand through, test and all other opcodes pass the
  accumulator through. Flags always follow the result.
*/
`timescale 1ns/1ps

module alu_flags
  import acc_cpu_pkg::*;
(
  input  op_e   op,
  input  word_t accum,
  input  word_t operand,
  output word_t result,
  output logic  zero,
  output logic  neg
);

  always_comb begin
    case (op)
      op_load: begin
        result = operand;
      end
      op_add: begin
        result = accum + operand;
      end
      op_sub: begin
        result = accum - operand;
      end
      op_and: begin
        result = accum & operand;
      end
      op_or: begin
        result = accum | operand;
      end
      op_xor: begin
        result = accum ^ operand;
      end
      default: begin
        result = accum;  // test, and anything without a data result.
      end
    endcase
  end

  assign zero = (result == '0);
  assign neg  = result[WORD_W-1];

endmodule

// File: src/mem_port.sv
/*
  Four-phase req/ack memory master, one read or write per start.
  start is ignored unless the port is idle.
  done pulses one cycle after ack is seen low again, at least three
  cycles after start. rdata holds the last read word until the next read.
*/
`timescale 1ns/1ps

module mem_port
  import acc_cpu_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,
  input  mem_cmd_t cmd,
  output logic     done,
  output word_t    rdata,
  output logic     mem_req,
  output mem_cmd_t mem_cmd,
  input  logic     mem_ack,
  input  word_t    mem_rdata
);

  typedef enum logic [1:0] {
    mp_idle,
    mp_req,
    mp_release
  } mp_state_e;

  mp_state_e state;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= mp_idle;
      mem_req <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        mp_idle: begin
          if (start) begin
            mem_req <= 1'b1;
            state   <= mp_req;
          end
        end
        mp_req: begin
          if (mem_ack) begin
            mem_req <= 1'b0;  // phase 3.
            state   <= mp_release;
          end
        end
        mp_release: begin
          if (!mem_ack) begin
            done  <= 1'b1;
            state <= mp_idle;
          end
        end
        default: begin
          state <= mp_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == mp_idle && start) begin
      mem_cmd <= cmd;
    end
    if (state == mp_req && mem_ack && !mem_cmd.write) begin
      rdata <= mem_rdata;
    end
  end

  a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req && !mem_ack |=> mem_req)
    else $error("mem_req dropped before mem_ack.");

  a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req |=> !mem_req || $stable(mem_cmd))
    else $error("mem_cmd changed during a request.");

endmodule

// File: src/cpu_control.sv
/*
  Processor sequencer: one instruction per step, fetch then exec, plus
  one memory phase for a direct memory operand or a store.
  The pc advances in exec, so a trap or halt leaves it past the
  instruction. A skipped instruction only advances the pc.
  Halt is left only by reset. Step is a level, sampled in idle and trap.
*/
`timescale 1ns/1ps

module cpu_control
  import acc_cpu_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         step,
  input  inst_fields_t fields,
  output word_t        inst,
  output word_t        alu_operand,
  input  word_t        alu_result,
  input  logic         alu_zero,
  input  logic         alu_neg,
  output word_t        accum,
  output logic         mem_start,
  output mem_cmd_t     mem_cmd,
  input  logic         mem_done,
  input  word_t        mem_rdata,
  output logic         busy,
  output logic         halt,
  output logic         trap,
  output logic [7:0]   data_out
);

  cpu_state_e state;
  addr_t      pc;
  addr_t      pc_next;
  addr_t      operand_addr;
  logic       zero;
  logic       neg;
  logic       skip;
  logic       cond_met;
  logic       data_op;
  logic       mem_op;

  assign pc_next      = pc + addr_t'(1);
  assign operand_addr = addr_t'(fields.operand);  // zero extended.

  always_comb begin
    case (fields.op)
      op_load, op_add, op_sub, op_and, op_or, op_xor: data_op = 1'b1;
      default:                                        data_op = 1'b0;
    endcase
  end

  assign mem_op = fields.use_mem && (data_op || fields.op == op_store);

  always_comb begin
    case (fields.cond)
      cond_zero:     cond_met = zero;
      cond_not_zero: cond_met = !zero;
      cond_neg:      cond_met = neg;
      default:       cond_met = !neg;
    endcase
  end

  // memory word feeds the alu only while the operand access is running.
  assign alu_operand = (state == st_mem) ? mem_rdata : fields.imm;

  assign busy = (state == st_fetch) || (state == st_exec) || (state == st_mem);
  assign halt = (state == st_halt);
  assign trap = (state == st_trap);

  // read at pc in fetch, operand address in mem. Valid with mem_start.
  always_comb begin
    mem_cmd.addr  = pc;
    mem_cmd.wdata = accum;
    mem_cmd.write = 1'b0;
    if (state == st_mem) begin
      mem_cmd.addr  = operand_addr;
      mem_cmd.write = (fields.op == op_store);
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_fetch && mem_done) begin
      inst <= mem_rdata;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state machine
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_idle;
      pc        <= RESET_PC;
      accum     <= '0;
      zero      <= 1'b0;
      neg       <= 1'b0;
      skip      <= 1'b0;
      data_out  <= '0;
      mem_start <= 1'b0;
    end else begin
      mem_start <= 1'b0;
      case (state)
        st_idle: begin
          if (step) begin
            state     <= st_fetch;
            mem_start <= 1'b1;
          end
        end
        st_fetch: begin
          if (mem_done) begin
            state <= st_exec;
          end
        end
        st_exec: begin
          state <= st_idle;
          pc    <= pc_next;
          skip  <= 1'b0;
          if (skip) begin
            state <= st_idle;  // skipped, pc only.
          end else if (fields.illegal) begin
            state <= st_trap;
          end else if (mem_op) begin
            state     <= st_mem;
            mem_start <= 1'b1;
          end else begin
            case (fields.op)
              op_halt:   state <= st_halt;
              op_trap:   state <= st_trap;
              op_if:     skip <= !cond_met;
              op_branch: pc <= pc_next + fields.imm;
              op_out_lo: data_out <= accum[7:0];
              op_out_hi: data_out <= accum[WORD_W-1:8];
              op_test: begin
                zero <= alu_zero;
                neg  <= alu_neg;
              end
              op_load, op_add, op_sub, op_and, op_or, op_xor: begin
                accum <= alu_result;
                zero  <= alu_zero;
                neg   <= alu_neg;
              end
              default: begin
                state <= st_idle;  // nop.
              end
            endcase
          end
        end
        st_mem: begin
          if (mem_done) begin
            state <= st_idle;
            if (fields.op != op_store) begin
              accum <= alu_result;
              zero  <= alu_zero;
              neg   <= alu_neg;
            end
          end
        end
        st_halt: begin
          state <= st_halt;
        end
        st_trap: begin
          if (step) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_trap;
        end
      endcase
    end
  end

  // halt holds until reset, with no bus activity and busy low.
  a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    state == st_halt |=> state == st_halt && !busy && !mem_start)
    else $error("processor left halt or went busy.");

endmodule

// File: src/acc_cpu_top.sv
/*
  Accumulator processor top level, wiring only.
  Memory is reached through a four-phase req/ack port with mem_cmd held
  for the whole request. The host steps one instruction at a time.
*/
`timescale 1ns/1ps

module acc_cpu_top
  import acc_cpu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       step,
  output logic       busy,
  output logic       halt,
  output logic       trap,
  output logic [7:0] data_out,
  output logic       mem_req,
  output mem_cmd_t   mem_cmd,
  input  logic       mem_ack,
  input  word_t      mem_rdata
);

  word_t        inst;
  inst_fields_t fields;
  word_t        accum;
  word_t        alu_operand;
  word_t        alu_result;
  logic         alu_zero;
  logic         alu_neg;
  logic         mem_start;
  mem_cmd_t     ctrl_cmd;
  logic         mem_done;
  word_t        port_rdata;

  inst_decoder u_inst_decoder (
    .inst   (inst),
    .fields (fields)
  );

  alu_flags u_alu_flags (
    .op      (fields.op),
    .accum   (accum),
    .operand (alu_operand),
    .result  (alu_result),
    .zero    (alu_zero),
    .neg     (alu_neg)
  );

  mem_port u_mem_port (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (mem_start),
    .cmd       (ctrl_cmd),
    .done      (mem_done),
    .rdata     (port_rdata),
    .mem_req   (mem_req),
    .mem_cmd   (mem_cmd),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  cpu_control u_cpu_control (
    .clk         (clk),
    .rst_n       (rst_n),
    .step        (step),
    .fields      (fields),
    .inst        (inst),
    .alu_operand (alu_operand),
    .alu_result  (alu_result),
    .alu_zero    (alu_zero),
    .alu_neg     (alu_neg),
    .accum       (accum),
    .mem_start   (mem_start),
    .mem_cmd     (ctrl_cmd),
    .mem_done    (mem_done),
    .mem_rdata   (port_rdata),
    .busy        (busy),
    .halt        (halt),
    .trap        (trap),
    .data_out    (data_out)
  );

endmodule

// File: test/acc_cpu_tb.sv
/*
  Directed testbench for the accumulator processor.
  Memory is a 256-word array behind a four-phase responder with 0 to 3
  cycles of random ack delay, so only the low 8 address bits are decoded.
  Each test resets the DUT, writes instructions at the expected pc and
  steps them one at a time. The fetch address is checked on every step.
*/
`timescale 1ns/1ps

module acc_cpu_tb
  import acc_cpu_pkg::*;
();

  localparam int clk_period = 20;

  // steps per test, used to size the watchdog.
  localparam int steps_reset = 1;
  localparam int steps_imm   = 18;
  localparam int steps_mem   = 15;
  localparam int steps_if    = 68;
  localparam int steps_trap  = 10;
  localparam int steps_halt  = 11;
  localparam int total_steps = steps_reset + steps_imm + steps_mem + steps_if +
                               steps_trap + steps_halt;
  localparam int watchdog_cycles = total_steps * 40 + 200;

  localparam logic [3:0] opc_nop    = 4'h0;
  localparam logic [3:0] opc_load   = 4'h1;
  localparam logic [3:0] opc_store  = 4'h2;
  localparam logic [3:0] opc_add    = 4'h3;
  localparam logic [3:0] opc_sub    = 4'h4;
  localparam logic [3:0] opc_and    = 4'h5;
  localparam logic [3:0] opc_or     = 4'h6;
  localparam logic [3:0] opc_xor    = 4'h7;
  localparam logic [3:0] opc_test   = 4'h8;
  localparam logic [3:0] opc_branch = 4'h9;
  localparam logic [3:0] opc_if     = 4'hA;
  localparam logic [3:0] opc_out_lo = 4'hB;
  localparam logic [3:0] opc_out_hi = 4'hC;
  localparam logic [3:0] opc_halt   = 4'hD;
  localparam logic [3:0] opc_trap   = 4'hE;
  localparam logic [3:0] opc_undef  = 4'hF;

  logic       clk       = 1'b0;
  logic       rst_n     = 1'b0;
  logic       step      = 1'b0;
  logic       mem_ack   = 1'b0;
  word_t      mem_rdata = '0;
  logic       busy;
  logic       halt;
  logic       trap;
  logic [7:0] data_out;
  logic       mem_req;
  mem_cmd_t   mem_cmd;

  word_t      mem [256];
  mem_cmd_t   req_log [$];   // every acked request since the last step.
  logic [1:0] ack_wait = 2'd0;
  integer     seed = 32'h31f1;
  addr_t      pc_model;
  word_t      acc_model;

  acc_cpu_top u_acc_cpu_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .step      (step),
    .busy      (busy),
    .halt      (halt),
    .trap      (trap),
    .data_out  (data_out),
    .mem_req   (mem_req),
    .mem_cmd   (mem_cmd),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  always #(clk_period / 2) clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [1:0] rand_delay();
    int r;
    r = $random(seed);
    return r[1:0];
  endfunction

  function automatic word_t fill_word(input logic [7:0] a);
    return {a, ~a};
  endfunction

  function automatic word_t encode(input logic [3:0] op, input logic use_mem,
                                   input logic [10:0] operand);
    return {op, use_mem, operand};
  endfunction

  function automatic word_t sign_extend(input logic [10:0] v);
    return {{5{v[10]}}, v};
  endfunction

  function automatic word_t apply_op(input logic [3:0] op, input word_t a, input word_t b);
    case (op)
      opc_load: return b;
      opc_add:  return a + b;
      opc_sub:  return a - b;
      opc_and:  return a & b;
      opc_or:   return a | b;
      opc_xor:  return a ^ b;
      default:  return a;
    endcase
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_out(input logic [7:0] exp, input string what);
    assert (data_out === exp)
      else fail_run($sformatf("Error: %0d ns: %s gave data_out %h, expected %h",
                              $time, what, data_out, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    assert (got === exp)
      else fail_run($sformatf("Error: %0d ns: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic check_access(input logic [10:0] addr, input logic write, input string what);
    assert (req_log.size() == 2 && req_log[1].addr === addr_t'(addr) &&
            req_log[1].write === write)
      else fail_run($sformatf("Error: %0d ns: %s did not access address %h",
                              $time, what, addr));
  endtask

  task automatic apply_reset;
    @(posedge clk);
    rst_n <= 1'b0;
    step  <= 1'b0;
    repeat (5) @(posedge clk);
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(i[7:0]);
    end
    rst_n <= 1'b1;
    pc_model  = RESET_PC;
    acc_model = '0;
    @(negedge clk);
  endtask

  task automatic press_step;
    @(posedge clk);
    step <= 1'b1;
    @(posedge clk);
    step <= 1'b0;
  endtask

  task automatic wait_idle;
    @(negedge clk);
    while (busy) begin
      @(negedge clk);
    end
  endtask

  // places one instruction at the expected pc and runs it.
  task automatic exec_inst(input word_t inst);
    mem[pc_model[7:0]] = inst;
    req_log.delete();
    press_step();
    wait_idle();
    assert (req_log.size() >= 1 && req_log[0].addr === pc_model && !req_log[0].write)
      else fail_run($sformatf("Error: %0d ns: instruction not fetched from %h",
                              $time, pc_model));
    pc_model = pc_model + addr_t'(1);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory responder
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) begin
    if (!rst_n) begin
      mem_ack  <= 1'b0;
      ack_wait <= rand_delay();
    end else if (mem_req && !mem_ack) begin
      if (ack_wait == 2'd0) begin
        mem_ack  <= 1'b1;
        ack_wait <= rand_delay();
        req_log.push_back(mem_cmd);
        if (mem_cmd.write) begin
          mem[mem_cmd.addr[7:0]] <= mem_cmd.wdata;
        end else begin
          mem_rdata <= mem[mem_cmd.addr[7:0]];
        end
      end else begin
        ack_wait <= ack_wait - 2'd1;
      end
    end else if (!mem_req && mem_ack) begin
      if (ack_wait == 2'd0) begin
        mem_ack  <= 1'b0;  // phase 4.
        ack_wait <= rand_delay();
      end else begin
        ack_wait <= ack_wait - 2'd1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_reset_state;
    apply_reset();
    check_bit(busy, 1'b0, "busy after reset");
    check_bit(halt, 1'b0, "halt after reset");
    check_bit(trap, 1'b0, "trap after reset");
    check_bit(mem_req, 1'b0, "mem_req after reset");
    check_out(8'h00, "reset");
    exec_inst(encode(opc_nop, 1'b0, 11'h000));  // first fetch must be address 0.
  endtask

  task automatic check_imm_ops;
    logic [3:0]  ops [6];
    logic [10:0] args [6];
    ops  = '{opc_load, opc_add, opc_sub, opc_and, opc_or, opc_xor};
    args = '{11'h123, 11'h7fb, 11'h3ff, 11'h70f, 11'h0f0, 11'h555};
    apply_reset();
    for (int i = 0; i < 6; i++) begin
      exec_inst(encode(ops[i], 1'b0, args[i]));
      acc_model = apply_op(ops[i], acc_model, sign_extend(args[i]));
      exec_inst(encode(opc_out_lo, 1'b0, 11'h000));
      check_out(acc_model[7:0], "immediate op, low byte");
      exec_inst(encode(opc_out_hi, 1'b0, 11'h000));
      check_out(acc_model[15:8], "immediate op, high byte");
    end
  endtask

  task automatic check_mem_ops;
    logic [10:0] a_ld;
    logic [10:0] a_add;
    logic [10:0] a_st;
    apply_reset();
    for (int k = 0; k < 3; k++) begin
      a_ld  = 11'h090 + 11'(k);
      a_add = 11'h0a5 + 11'(3 * k);
      a_st  = 11'h0c3 + 11'(k);
      exec_inst(encode(opc_load, 1'b1, a_ld));
      check_access(a_ld, 1'b0, "memory load");
      acc_model = fill_word(a_ld[7:0]);
      exec_inst(encode(opc_add, 1'b1, a_add));
      check_access(a_add, 1'b0, "memory add");
      acc_model = acc_model + fill_word(a_add[7:0]);
      exec_inst(encode(opc_store, 1'b1, a_st));
      check_access(a_st, 1'b1, "store");
      assert (mem[a_st[7:0]] === acc_model)
        else fail_run($sformatf("Error: %0d ns: stored word %h, expected %h",
                                $time, mem[a_st[7:0]], acc_model));
      exec_inst(encode(opc_out_lo, 1'b0, 11'h000));
      check_out(acc_model[7:0], "sum, low byte");
      exec_inst(encode(opc_out_hi, 1'b0, 11'h000));
      check_out(acc_model[15:8], "sum, high byte");
    end
  endtask

  task automatic check_if_branch;
    logic [10:0] vals [3];
    word_t       val;
    logic        met;
    vals = '{11'h000, 11'h005, 11'h7f0};
    apply_reset();
    // test on the zero accumulator left by reset, no data op before it.
    exec_inst(encode(opc_test, 1'b0, 11'h000));
    exec_inst(encode(opc_if, 1'b0, 11'h000));
    exec_inst(encode(opc_load, 1'b0, 11'h02a));
    exec_inst(encode(opc_out_lo, 1'b0, 11'h000));
    check_out(8'h2a, "if on zero after test of reset accumulator");
    for (int i = 0; i < 3; i++) begin
      for (int c = 0; c < 4; c++) begin
        val = sign_extend(vals[i]);
        case (c)
          0:       met = (val == '0);
          1:       met = (val != '0);
          2:       met = val[15];
          default: met = !val[15];
        endcase
        exec_inst(encode(opc_load, 1'b0, vals[i]));
        exec_inst(encode(opc_test, 1'b0, 11'h000));
        exec_inst(encode(opc_if, 1'b0, 11'(c)));
        exec_inst(encode(opc_load, 1'b0, 11'h02a));  // runs only if the condition held.
        exec_inst(encode(opc_out_lo, 1'b0, 11'h000));
        check_out(met ? 8'h2a : val[7:0], $sformatf("if with condition %0d", c));
      end
    end
    exec_inst(encode(opc_branch, 1'b0, 11'h006));
    pc_model = pc_model + sign_extend(11'h006);
    exec_inst(encode(opc_nop, 1'b0, 11'h000));
    exec_inst(encode(opc_branch, 1'b0, 11'h7e0));
    pc_model = pc_model + sign_extend(11'h7e0);
    exec_inst(encode(opc_nop, 1'b0, 11'h000));
  endtask

  task automatic check_traps;
    word_t traps [3];
    traps = '{encode(opc_store, 1'b0, 11'h010), encode(opc_undef, 1'b0, 11'h123),
              encode(opc_trap, 1'b0, 11'h000)};
    apply_reset();
    exec_inst(encode(opc_load, 1'b0, 11'h055));
    for (int i = 0; i < 3; i++) begin
      exec_inst(traps[i]);
      check_bit(trap, 1'b1, "trap");
      assert (req_log.size() == 1)
        else fail_run("a trapping instruction made a data access");
      press_step();
      @(negedge clk);
      check_bit(trap, 1'b0, "trap after step");
      exec_inst(encode(opc_out_lo, 1'b0, 11'h000));
      check_out(8'h55, "resume after trap");
    end
  endtask

  task automatic check_halt;
    apply_reset();
    exec_inst(encode(opc_load, 1'b0, 11'h03c));
    exec_inst(encode(opc_out_lo, 1'b0, 11'h000));
    check_out(8'h3c, "before halt");
    exec_inst(encode(opc_load, 1'b0, 11'h001));
    exec_inst(encode(opc_test, 1'b0, 11'h000));
    exec_inst(encode(opc_if, 1'b0, 11'h000));  // fails, accumulator is not zero.
    exec_inst(encode(opc_halt, 1'b0, 11'h000));
    check_bit(halt, 1'b0, "halt after a skipped halt");
    exec_inst(encode(opc_out_lo, 1'b0, 11'h000));
    check_out(8'h01, "after skipped halt");
    exec_inst(encode(opc_halt, 1'b0, 11'h000));
    check_bit(halt, 1'b1, "halt");
    repeat (3) begin
      press_step();
      repeat (4) begin
        @(negedge clk);
        check_bit(busy, 1'b0, "busy in halt");
        check_bit(mem_req, 1'b0, "mem_req in halt");
      end
      check_bit(halt, 1'b1, "halt after step");
      check_out(8'h01, "halted");
    end
  endtask

  initial begin
    #(watchdog_cycles * clk_period);
    fail_run("timeout: the tests did not finish in the expected time");
  end

  initial begin
    check_reset_state();
    check_imm_ops();
    check_mem_ops();
    check_if_branch();
    check_traps();
    check_halt();
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: sim.f
src/acc_cpu_pkg.sv
src/inst_decoder.sv
src/alu_flags.sv
src/mem_port.sv
src/cpu_control.sv
src/acc_cpu_top.sv
test/acc_cpu_tb.sv
